//--- lsu_top.f
+incdir+hw
+incdir+bench
hw/lsu_pkg.sv
hw/lsu_issue.sv
hw/lsu_writeback.sv
hw/lsu_top.sv
bench/lsu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps
TOP       = lsu_tb
FILELIST  = lsu_top.f
PASS_MSG  = Finished with no errors

.PHONY: simulate clean

# build, run, then look for the pass line in the output
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- bench/lsu_tb_checks.svh
// typed compare tasks and first error stop for the access stage testbench

`ifndef LSU_TB_CHECKS_SVH
`define LSU_TB_CHECKS_SVH

// ========================================
// stop on first failure
// ========================================
task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
endtask

// ========================================
// one compare per result type
// ========================================
task automatic flag_is(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("ERR %0t: %s got %b expected %b", $time, name, got, exp));
    end
endtask

task automatic lanes_are(input string name, input byte_en_t got, input byte_en_t exp);
    if (got !== exp) begin
        abort_run($sformatf("ERR %0t: %s got %b expected %b", $time, name, got, exp));
    end
endtask

task automatic word_is(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
        abort_run($sformatf("ERR %0t: %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic rd_is(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
        abort_run($sformatf("ERR %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
endtask

// word index on the register bus
task automatic mm_index_is(input string name, input mm_reg_addr_t got, input mm_reg_addr_t exp);
    if (got !== exp) begin
        abort_run($sformatf("ERR %0t: %s got %h expected %h", $time, name, got, exp));
    end
endtask

`endif

//--- bench/lsu_tb.sv
// testbench for the data access stage with random requests, a bus responder and a model
`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int NUM_REQ     = 2000;
    localparam int MAX_CYCLES  = NUM_REQ * 10;  // worst request fits in 10 cycles
    localparam int DRIVE_DELAY = 1;

    logic         clk;
    logic         reset_n;
    logic         access_enable;
    lsu_req_t     req;
    logic         save_to_rd;
    reg_addr_t    rd_addr;
    xlen_t        rd_data;
    logic         mem_enable_in;
    xlen_t        mem_rdata;
    logic         mem_re;
    byte_en_t     mem_we;
    xlen_t        mem_wdata;
    xlen_t        mem_addr;
    logic         mm_reg_enable_in;
    xlen_t        mm_reg_rdata;
    logic         mm_reg_re;
    logic         mm_reg_we;
    xlen_t        mm_reg_wdata;
    mm_reg_addr_t mm_reg_addr;
    logic         store_done;
    logic         load_done;
    logic         exception_alignment;
    logic         reg_we;
    xlen_t        reg_wdata;
    reg_addr_t    reg_addr;

    integer seed   = 32'h34808599;
    int     cycles = 0;
    logic   resp_mem;   // responder answers on the memory bus
    xlen_t  resp_word;
    int     resp_gap;

    `include "lsu_tb_checks.svh"

    lsu_top i_dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run("timeout: the requests did not complete within the cycle limit");
        end
    end

    // ========================================
    // model helpers
    // ========================================
    // read data on both buses is a fixed function of the address
    function automatic xlen_t bus_word(input xlen_t a);
        return (a * 32'h9e37_79b1) ^ 32'h3c5a_a5c3;
    endfunction

    function automatic int width_bytes(input ls_width_e w);
        case (w)
            lb, lbu: return 1;
            lh, lhu: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic xlen_t load_expect(input ls_width_e w, input int off, input xlen_t word);
        xlen_t mask;
        xlen_t val;
        int    nbytes;
        nbytes = width_bytes(w);
        mask   = (nbytes == 4) ? 32'hffff_ffff : (32'd1 << (8 * nbytes)) - 32'd1;
        val    = (word >> (8 * off)) & mask;
        if ((w == lb || w == lh) && (val & ~(mask >> 1)) != 32'd0) begin
            val = val | ~mask;  // sign fill above the field
        end
        return val;
    endfunction

    task automatic strobes_are(input logic re, input byte_en_t we, input logic mre,
                               input logic mwe, input logic sd, input logic exc,
                               input logic ld, input logic rwe);
        flag_is("mem_re", mem_re, re);
        lanes_are("mem_we", mem_we, we);
        flag_is("mm_reg_re", mm_reg_re, mre);
        flag_is("mm_reg_we", mm_reg_we, mwe);
        flag_is("store_done", store_done, sd);
        flag_is("exception_alignment", exception_alignment, exc);
        flag_is("load_done", load_done, ld);
        flag_is("reg_we", reg_we, rwe);
    endtask

    task automatic all_quiet();
        strobes_are(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    // ========================================
    // load responder
    // ========================================
    always @(negedge clk) begin
        if (reset_n && (mem_re || mm_reg_re)) begin
            resp_mem  = mem_re;
            resp_word = mem_re ? bus_word(mem_addr) : bus_word(xlen_t'(mm_reg_addr));
            resp_gap  = 1 + ($unsigned($random(seed)) % 4);  // 1 to 4 cycles
            repeat (resp_gap) @(posedge clk);
            #DRIVE_DELAY;
            mem_enable_in    = resp_mem;
            mm_reg_enable_in = !resp_mem;
            mem_rdata        = resp_mem ? resp_word : ~resp_word;  // wrong bus gets junk
            mm_reg_rdata     = resp_mem ? ~resp_word : resp_word;
            @(posedge clk);
            #DRIVE_DELAY;
            mem_enable_in    = 1'b0;
            mm_reg_enable_in = 1'b0;
        end
    end

    // ========================================
    // one random request and its checks
    // ========================================
    task automatic run_request();
        int        kind;     // 0 load, 1 store, 2 pass-through
        int        gap;
        int        off;
        logic      to_reg;
        logic      aligned;
        xlen_t     addr;
        xlen_t     word;
        xlen_t     data;     // store payload
        byte_en_t  lanes;
        ls_width_e width;
        @(posedge clk);
        #DRIVE_DELAY;
        gap  = $unsigned($random(seed)) % 3;
        kind = $unsigned($random(seed)) % 3;
        case ($unsigned($random(seed)) % 5)
            0:       width = lb;
            1:       width = lh;
            2:       width = lw;
            3:       width = lbu;
            default: width = lhu;
        endcase
        addr   = $random(seed);
        to_reg = addr[31];
        addr[`LSU_MEM_SPACE_BIT] = !to_reg;
        addr[`LSU_REG_SPACE_BIT] = to_reg;
        off     = {30'd0, addr[1:0]};
        aligned = (off % width_bytes(width)) == 0;
        repeat (gap) begin
            @(negedge clk);
            all_quiet();  // nothing between requests
            @(posedge clk);
            #DRIVE_DELAY;
        end
        word           = $random(seed);
        rd_addr        = word[4:0];
        rd_data        = $random(seed);
        data           = $random(seed);
        req.load       = (kind == 0);
        req.store      = (kind == 1);
        req.width      = width;
        req.addr       = addr;
        req.store_data = data;
        save_to_rd     = (kind == 2);
        access_enable  = 1'b1;
        @(negedge clk);
        // memory read and pass-through write show in the enable cycle
        strobes_are(kind == 0 && aligned && !to_reg, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                    kind == 2);
        if (kind == 0 && aligned && !to_reg) begin
            word_is("mem_addr", mem_addr, addr);
        end
        if (kind == 2) begin
            word_is("reg_wdata", reg_wdata, rd_data);
            rd_is("reg_addr", reg_addr, rd_addr);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        access_enable  = 1'b0;
        save_to_rd     = 1'b0;
        req.addr       = ~addr;  // request bus no longer valid
        req.store_data = ~data;
        @(negedge clk);
        if (kind == 2) begin
            all_quiet();
        end else if (!aligned) begin
            strobes_are(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        end else if (kind == 1) begin
            lanes = to_reg ? '0 : byte_en_t'(((32'd1 << width_bytes(width)) - 32'd1) << off);
            strobes_are(1'b0, lanes, 1'b0, to_reg, 1'b1, 1'b0, 1'b0, 1'b0);
            word_is("mem_addr", mem_addr, addr);
            if (to_reg) begin
                mm_index_is("mm_reg_addr", mm_reg_addr, addr[9:2]);
                word_is("mm_reg_wdata", mm_reg_wdata, data);
            end else begin
                word_is("mem_wdata", mem_wdata, data << (8 * off));
            end
        end else begin
            flag_is("mem_re", mem_re, 1'b0);
            flag_is("mm_reg_re", mm_reg_re, to_reg);  // register bus reads one cycle late
            flag_is("mm_reg_we", mm_reg_we, 1'b0);
            flag_is("store_done", store_done, 1'b0);
            flag_is("exception_alignment", exception_alignment, 1'b0);
            lanes_are("mem_we", mem_we, '0);
            while (!load_done) begin
                flag_is("reg_we", reg_we, 1'b0);
                @(negedge clk);
                if (!load_done) begin
                    all_quiet();  // nothing moves while waiting
                end
            end
            strobes_are(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
            rd_is("reg_addr", reg_addr, rd_addr);
            word = to_reg ? bus_word(xlen_t'(addr[9:2])) : bus_word(addr);
            word_is("reg_wdata", reg_wdata, load_expect(width, off, word));
        end
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        reset_n          = 1'b0;
        access_enable    = 1'b0;
        req              = '0;
        save_to_rd       = 1'b0;
        rd_addr          = '0;
        rd_data          = '0;
        mem_enable_in    = 1'b0;
        mem_rdata        = '0;
        mm_reg_enable_in = 1'b0;
        mm_reg_rdata     = '0;
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        reset_n = 1'b1;
        @(negedge clk);
        all_quiet();  // everything low out of reset
        for (int n = 0; n < NUM_REQ; n++) begin
            run_request();
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- hw/lsu_top.sv
// data access stage top joining the access sequencer and the writeback
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; (
    input  logic         clk,
    input  logic         reset_n,
    // execution unit side
    input  logic         access_enable,
    input  lsu_req_t     req,
    input  logic         save_to_rd,
    input  reg_addr_t    rd_addr,
    input  xlen_t        rd_data,
    // memory bus
    input  logic         mem_enable_in,
    input  xlen_t        mem_rdata,
    output logic         mem_re,
    output byte_en_t     mem_we,
    output xlen_t        mem_wdata,
    output xlen_t        mem_addr,
    // register region bus
    input  logic         mm_reg_enable_in,
    input  xlen_t        mm_reg_rdata,
    output logic         mm_reg_re,
    output logic         mm_reg_we,
    output xlen_t        mm_reg_wdata,
    output mm_reg_addr_t mm_reg_addr,
    // status
    output logic         store_done,
    output logic         load_done,
    output logic         exception_alignment,
    // register file write port
    output logic         reg_we,
    output xlen_t        reg_wdata,
    output reg_addr_t    reg_addr
);

    load_ctx_t load_ctx;  // width and offset of the pending load

    lsu_issue i_issue (
        .clk                 (clk),
        .reset_n             (reset_n),
        .access_enable       (access_enable),
        .req                 (req),
        .mem_enable_in       (mem_enable_in),
        .mm_reg_enable_in    (mm_reg_enable_in),
        .mem_re              (mem_re),
        .mem_we              (mem_we),
        .mem_wdata           (mem_wdata),
        .mem_addr            (mem_addr),
        .mm_reg_re           (mm_reg_re),
        .mm_reg_we           (mm_reg_we),
        .mm_reg_wdata        (mm_reg_wdata),
        .mm_reg_addr         (mm_reg_addr),
        .store_done          (store_done),
        .load_done           (load_done),
        .exception_alignment (exception_alignment),
        .load_ctx            (load_ctx)
    );

    lsu_writeback i_writeback (
        .access_enable (access_enable),
        .save_to_rd    (save_to_rd),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .load_done     (load_done),
        .load_ctx      (load_ctx),
        .mem_enable_in (mem_enable_in),
        .mem_rdata     (mem_rdata),
        .mm_reg_rdata  (mm_reg_rdata),
        .reg_we        (reg_we),
        .reg_wdata     (reg_wdata),
        .reg_addr      (reg_addr)
    );

endmodule

//--- hw/lsu_writeback.sv
// load data alignment, extension and register file write selection
`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_writeback import lsu_pkg::*; (
    input  logic      access_enable,
    input  logic      save_to_rd,      // execution result wants rd
    input  reg_addr_t rd_addr,
    input  xlen_t     rd_data,
    input  logic      load_done,       // response cycle of a load
    input  load_ctx_t load_ctx,
    input  logic      mem_enable_in,
    input  xlen_t     mem_rdata,
    input  xlen_t     mm_reg_rdata,
    output logic      reg_we,
    output xlen_t     reg_wdata,
    output reg_addr_t reg_addr
);

    xlen_t rdata_sel;      // word from the answering region
    xlen_t rdata_aligned;  // addressed byte moved to lane 0
    xlen_t load_result;

    // ========================================
    // load return path
    // ========================================
    // memory has priority when both answer
    assign rdata_sel = mem_enable_in ? mem_rdata : mm_reg_rdata;

    assign rdata_aligned = rdata_sel >> {load_ctx.offset, 3'b000};

    always_comb begin
        case (load_ctx.width)
            lb: begin
                load_result = {{(`LSU_XLEN-8){rdata_aligned[7]}}, rdata_aligned[7:0]};
            end
            lh: begin
                load_result = {{(`LSU_XLEN-16){rdata_aligned[15]}}, rdata_aligned[15:0]};
            end
            lbu: begin
                load_result = {{(`LSU_XLEN-8){1'b0}}, rdata_aligned[7:0]};
            end
            lhu: begin
                load_result = {{(`LSU_XLEN-16){1'b0}}, rdata_aligned[15:0]};
            end
            default: begin
                load_result = rdata_aligned;  // lw as is
            end
        endcase
    end

    // ========================================
    // register file port
    // ========================================
    // pass-through writes happen in the enable cycle
    assign reg_we    = load_done || (access_enable && save_to_rd);
    assign reg_wdata = load_done ? load_result : rd_data;
    assign reg_addr  = rd_addr;  // source holds rd until load_done

endmodule

//--- hw/lsu_issue.sv
// access sequencer that checks alignment, decodes the region and drives bus strobes
`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_issue import lsu_pkg::*; (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         access_enable,        // one pulse per request
    input  lsu_req_t     req,
    input  logic         mem_enable_in,        // memory read response
    input  logic         mm_reg_enable_in,     // register region read response
    output logic         mem_re,
    output byte_en_t     mem_we,
    output xlen_t        mem_wdata,
    output xlen_t        mem_addr,
    output logic         mm_reg_re,
    output logic         mm_reg_we,
    output xlen_t        mm_reg_wdata,
    output mm_reg_addr_t mm_reg_addr,
    output logic         store_done,
    output logic         load_done,
    output logic         exception_alignment,
    output load_ctx_t    load_ctx
);

    lsu_state_e   state;
    lsu_state_e   state_nxt;
    byte_offset_t offset;
    logic         mem_sel;       // memory region bit
    logic         reg_sel;       // register region bit
    logic         accept;        // request taken this cycle
    logic         misaligned;
    logic         store_go;      // aligned store, strobes next cycle
    logic         load_go;       // aligned load, wait for response
    logic         bad_access;
    logic         resp;          // either region answered
    byte_en_t     lane_mask;
    xlen_t        store_addr;    // held for the write cycle

    // ========================================
    // request decode
    // ========================================
    assign offset  = req.addr[1:0];
    assign mem_sel = req.addr[`LSU_MEM_SPACE_BIT];
    assign reg_sel = req.addr[`LSU_REG_SPACE_BIT];
    assign accept  = access_enable && (state == idle);  // enables outside idle are dropped
    assign resp    = mem_enable_in || mm_reg_enable_in;

    always_comb begin
        case (req.width[1:0])
            2'b00:   misaligned = 1'b0;       // bytes go anywhere
            2'b01:   misaligned = offset[0];  // half needs even address
            default: misaligned = |offset;    // word boundary only
        endcase
    end

    // store wins if both flags are set
    assign store_go   = accept && req.store && !misaligned;
    assign load_go    = accept && !req.store && req.load && !misaligned;
    assign bad_access = accept && (req.store || req.load) && misaligned;

    // lanes start at the byte offset
    always_comb begin
        case (req.width[1:0])
            2'b00:   lane_mask = byte_en_t'(4'b0001) << offset;
            2'b01:   lane_mask = byte_en_t'(4'b0011) << offset;
            default: lane_mask = '1;
        endcase
    end

    // ========================================
    // sequencer
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (bad_access) begin
                    state_nxt = exception;
                end else if (load_go) begin
                    state_nxt = load_wait;
                end
            end
            exception: state_nxt = idle;  // one cycle report
            load_wait: begin
                if (resp) begin
                    state_nxt = idle;
                end
            end
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= idle;
            mem_we     <= '0;
            mm_reg_we  <= 1'b0;
            mm_reg_re  <= 1'b0;
            store_done <= 1'b0;
        end else begin
            state      <= state_nxt;
            mem_we     <= (store_go && mem_sel) ? lane_mask : '0;
            mm_reg_we  <= store_go && reg_sel;
            mm_reg_re  <= load_go && reg_sel;  // register bus reads a cycle late
            store_done <= store_go;
        end
    end

    // payload follows the accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            mem_wdata    <= req.store_data << {offset, 3'b000};
            mm_reg_wdata <= req.store_data;  // word wide, no lane shift
            mm_reg_addr  <= req.addr[`LSU_MM_REG_ADDR_BITS+1:2];
            store_addr   <= req.addr;
        end
        if (load_go) begin
            load_ctx.width  <= req.width;
            load_ctx.offset <= offset;
        end
    end

    // ========================================
    // combinational strobes
    // ========================================
    assign mem_re              = load_go && mem_sel;  // same cycle as enable
    assign mem_addr            = store_done ? store_addr : req.addr;
    assign load_done           = (state == load_wait) && resp;
    assign exception_alignment = (state == exception);

endmodule

//--- hw/lsu_pkg.sv
// vector types, enums and request structs shared by the access stage

`include "lsu_settings.svh"

package lsu_pkg;

    // ========================================
    // plain vectors
    // ========================================
    typedef logic [`LSU_XLEN-1:0]             xlen_t;         // data or address word
    typedef logic [`LSU_XLEN_BYTES-1:0]       byte_en_t;      // one bit per lane
    typedef logic [`LSU_REG_ADDR_BITS-1:0]    reg_addr_t;     // rd index
    typedef logic [`LSU_MM_REG_ADDR_BITS-1:0] mm_reg_addr_t;  // register region word index
    typedef logic [1:0]                       byte_offset_t;  // addr[1:0]

    // ========================================
    // enums
    // ========================================
    // funct3 width codes of the RISC-V load/store group
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } ls_width_e;

    typedef enum logic [1:0] {
        idle,       // ready for a request
        exception,  // misaligned request seen last cycle
        load_wait   // read strobe out, no response yet
    } lsu_state_e;

    // request from the execution unit
    typedef struct packed {
        logic      load;
        logic      store;
        ls_width_e width;
        xlen_t     addr;
        xlen_t     store_data;
    } lsu_req_t;

    // what the writeback needs to shape a load result
    typedef struct packed {
        ls_width_e    width;
        byte_offset_t offset;
    } load_ctx_t;

endpackage

//--- hw/lsu_settings.svh
// access stage constants for bus widths and region select bits

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// ========================================
// data path widths
// ========================================
`define LSU_XLEN              32    // data and address word
`define LSU_XLEN_BYTES        4     // byte lanes per word
`define LSU_REG_ADDR_BITS     5     // register file index

// ========================================
// address map
// ========================================
`define LSU_MM_REG_ADDR_BITS  8     // word index into register region

// one address bit per region
`define LSU_MEM_SPACE_BIT     28
`define LSU_REG_SPACE_BIT     29

`endif
